// ==== hdl/word_pkg.sv ====
// data word union, byte lane type, lane constants and lane to byte position helper
package word_pkg;

    // number of byte lanes in one host bus word
    localparam int LANES = 4;

    // byte offset BO as carried on the control bus
    // lane 0 is the most significant byte of the word
    typedef logic [1:0] lane_t;

    // upper-upper byte, bits 31:24
    localparam lane_t LANE_UU = 2'd0;
    // upper-middle byte, bits 23:16
    localparam lane_t LANE_UM = 2'd1;
    // lower-middle byte, bits 15:8
    localparam lane_t LANE_LM = 2'd2;
    // lower-lower byte, bits 7:0, last lane of a word
    localparam lane_t LANE_LL = 2'd3;

    // one 32-bit word seen two ways
    // bytes[3] is bits 31:24, bytes[0] is bits 7:0
    // halves[1] is bits 31:16, halves[0] is bits 15:0
    typedef union packed {
        // byte view for the FIFO and the SCSI lanes
        logic [LANES-1:0][7:0] bytes;
        // 16-bit view for the CPU register path
        logic [1:0][15:0]      halves;
    } data_word_u;

    // maps a lane number onto its index in the bytes view
    // lane 0 lands on bytes[3], lane 3 on bytes[0]
    function automatic logic [1:0] byte_pos(input lane_t lane);
        logic [1:0] top;
        top = 2'(LANES - 1);
        return top - lane;
    endfunction

endpackage

// ==== hdl/xfer_pkg.sv ====
// transfer control struct and FIFO status struct
package xfer_pkg;

    // per-cycle transfer control, driven as plain levels
    // at most one of the four direction strobes is high at a time
    typedef struct packed {
        // CPU write data out to the SCSI bus
        logic                cpu2s;
        // SCSI byte into the CPU read register
        logic                s2cpu;
        // SCSI byte into the FIFO packing register
        logic                s2f;
        // FIFO head word out to the SCSI bus
        logic                f2s;
        // CPU half select, high picks bits 23:16, low picks bits 7:0
        logic                a3;
        // byte offset within the FIFO word
        word_pkg::lane_t     bo;
    } xfer_ctrl_t;

    // word FIFO occupancy flags
    typedef struct packed {
        // no room for another packed word
        logic full;
        // nothing stored, head reads as zero
        logic empty;
    } fifo_stat_t;

endpackage

// ==== hdl/scsi_tx_select.sv ====
// byte lane decoder and six-way transmit byte multiplexer
`timescale 1ns/100ps

module scsi_tx_select (
    input  xfer_pkg::xfer_ctrl_t ctrl,
    input  word_pkg::data_word_u fifo_head,
    input  word_pkg::data_word_u cpu_wdata,
    output logic [7:0]           tx_byte
);

    // one bit per transmit source, at most one set
    typedef struct packed {
        logic uu;
        logic um;
        logic lm;
        logic ll;
        logic cpu_hi;
        logic cpu_lo;
    } tx_sel_t;

    tx_sel_t sel;

    // 2-to-4 lane decoder, enabled by f2s
    // plus the two CPU half selects
    always_comb begin
        sel = '0;
        if (ctrl.f2s) begin
            case (ctrl.bo)
                word_pkg::LANE_UU: sel.uu = 1'b1;
                word_pkg::LANE_UM: sel.um = 1'b1;
                word_pkg::LANE_LM: sel.lm = 1'b1;
                word_pkg::LANE_LL: sel.ll = 1'b1;
                default:           sel    = '0;
            endcase
        end
        // a3 high takes the upper CPU byte
        sel.cpu_hi = ctrl.cpu2s & ctrl.a3;
        sel.cpu_lo = ctrl.cpu2s & ~ctrl.a3;
    end

    // and-or multiplexer over one-hot selects
    // no select active gives a zero byte
    always_comb begin
        tx_byte = '0;
        // FIFO head lanes, msb lane first
        tx_byte |= {8{sel.uu}} & fifo_head.bytes[3];
        tx_byte |= {8{sel.um}} & fifo_head.bytes[2];
        tx_byte |= {8{sel.lm}} & fifo_head.bytes[1];
        tx_byte |= {8{sel.ll}} & fifo_head.bytes[0];
        // CPU write data, bits 23:16 or bits 7:0
        tx_byte |= {8{sel.cpu_hi}} & cpu_wdata.bytes[2];
        tx_byte |= {8{sel.cpu_lo}} & cpu_wdata.bytes[0];
    end

endmodule

// ==== hdl/scsi_datapath.sv ====
// SCSI direction control, receive latch, receive byte replication and CPU read word
`timescale 1ns/100ps

module scsi_datapath (
    input  logic                 LS2CPU,
    input  logic                 rst_n,
    input  xfer_pkg::xfer_ctrl_t ctrl,
    input  word_pkg::data_word_u cpu_wdata,
    input  word_pkg::data_word_u fifo_head,
    input  logic [7:0]           scsi_rx,
    output logic [7:0]           scsi_tx,
    output logic                 scsi_oe,
    output word_pkg::data_word_u mod,
    output word_pkg::data_word_u fifo_wdata
);

    // bus is driven towards SCSI
    logic       scsi_out;
    // bus is sampled from SCSI
    logic       scsi_in;
    // receive byte, zero unless a receive strobe is up
    logic [7:0] rx_gated;
    // last received byte for CPU reads
    logic [7:0] rx_latch;

    // transmit byte selection
    scsi_tx_select u_tx_select (
        .ctrl      (ctrl),
        .fifo_head (fifo_head),
        .cpu_wdata (cpu_wdata),
        .tx_byte   (scsi_tx)
    );

    // direction from the strobes
    assign scsi_out = ctrl.cpu2s | ctrl.f2s;
    assign scsi_in  = ctrl.s2cpu | ctrl.s2f;

    // output enable for the external pad driver
    assign scsi_oe = scsi_out;

    // idle receive path reads as zero
    assign rx_gated = scsi_in ? scsi_rx : 8'h00;

    // receive latch
    // samples every edge while either receive strobe is high
    always_ff @(posedge LS2CPU) begin
        if (!rst_n) begin
            rx_latch <= 8'h00;
        end else if (scsi_in) begin
            rx_latch <= rx_gated;
        end
    end

    // CPU read word
    // latched byte sits in the upper byte of each 16-bit half
    always_comb begin
        mod = '0;
        if (ctrl.s2cpu) begin
            mod.halves[1] = {rx_latch, 8'h00};
            mod.halves[0] = {rx_latch, 8'h00};
        end
    end

    // receive byte copied onto all four lanes
    // the FIFO picks the lane it needs from bo
    always_comb begin
        fifo_wdata = '0;
        for (int i = 0; i < word_pkg::LANES; i++) begin
            fifo_wdata.bytes[i] = rx_gated;
        end
    end

endmodule

// ==== hdl/dma_fifo.sv ====
// word FIFO with byte packing on write and lane-wise unpacking on read
`timescale 1ns/100ps

module dma_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 LS2CPU,
    input  logic                 rst_n,
    input  xfer_pkg::xfer_ctrl_t ctrl,
    input  word_pkg::data_word_u fifo_wdata,
    output word_pkg::data_word_u fifo_head,
    output xfer_pkg::fifo_stat_t stat
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

    // word storage
    word_pkg::data_word_u mem [FIFO_DEPTH];

    // packing register, one lane filled per s2f cycle
    word_pkg::data_word_u pack_q;
    // packing register with the current byte merged in
    word_pkg::data_word_u push_word;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // index of bo within the bytes view
    logic [1:0] lane_pos;
    logic       last_lane;
    logic       full;
    logic       empty;
    logic       push;
    logic       pop;

    // circular pointer step, wraps for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign lane_pos  = word_pkg::byte_pos(ctrl.bo);
    assign last_lane = (ctrl.bo == word_pkg::LANE_LL);

    assign full  = (count == DEPTH_CNT);
    assign empty = (count == '0);
    assign stat  = '{full: full, empty: empty};

    // word completes on the last lane
    // dropped when full, nothing pops when empty
    assign push = ctrl.s2f & last_lane & ~full;
    assign pop  = ctrl.f2s & last_lane & ~empty;

    // merge the incoming byte so the pushed word carries all four lanes
    always_comb begin
        push_word = pack_q;
        push_word.bytes[lane_pos] = fifo_wdata.bytes[lane_pos];
    end

    // packing register takes the byte even when the push is dropped
    always_ff @(posedge LS2CPU) begin
        if (!rst_n) begin
            pack_q <= '0;
        end else if (ctrl.s2f) begin
            pack_q <= push_word;
        end
    end

    always_ff @(posedge LS2CPU) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // pointers and occupancy
    always_ff @(posedge LS2CPU) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word, zero while empty so an underrun sends zero
    assign fifo_head = empty ? '0 : mem[rd_ptr];

endmodule

// ==== hdl/sdmac_datapath.sv ====
// top level joining the SCSI byte datapath and the word FIFO
`timescale 1ns/100ps

module sdmac_datapath #(
    parameter int FIFO_DEPTH = 8
) (
    // SCSI side clock
    input  logic                 LS2CPU,
    input  logic                 rst_n,
    // direction strobes, CPU half select and byte offset
    input  xfer_pkg::xfer_ctrl_t ctrl,
    // CPU register write data
    input  word_pkg::data_word_u cpu_wdata,
    // SCSI data bus, receive side of the pad
    input  logic [7:0]           scsi_rx,
    // SCSI data bus, transmit side of the pad
    output logic [7:0]           scsi_tx,
    output logic                 scsi_oe,
    // CPU read data
    output word_pkg::data_word_u mod,
    // FIFO full and empty
    output xfer_pkg::fifo_stat_t stat
);

    // head word of the FIFO, feeds the transmit multiplexer
    word_pkg::data_word_u fifo_head;
    // received byte on all lanes, feeds the packing register
    word_pkg::data_word_u fifo_wdata;

    // byte steering between SCSI, CPU and FIFO
    scsi_datapath u_scsi_datapath (
        .LS2CPU     (LS2CPU),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .cpu_wdata  (cpu_wdata),
        .fifo_head  (fifo_head),
        .scsi_rx    (scsi_rx),
        .scsi_tx    (scsi_tx),
        .scsi_oe    (scsi_oe),
        .mod        (mod),
        .fifo_wdata (fifo_wdata)
    );

    // packing word FIFO
    // uses only s2f, f2s and bo of ctrl
    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dma_fifo (
        .LS2CPU     (LS2CPU),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .fifo_wdata (fifo_wdata),
        .fifo_head  (fifo_head),
        .stat       (stat)
    );

endmodule

// ==== sim/tb_tasks.svh ====
// LCG, value compare helper, bus stepping tasks and the directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

    // generator state, fixed seed so every run sees the same data
    logic [31:0] lcg_state = 32'h27bf8171;

    // 32-bit linear congruential step
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the LCG have the longest period
    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = next_random();
        return r[31:24];
    endfunction

    // four fresh bytes, lane 0 in bits 31:24
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = {random_byte(), random_byte(), random_byte(), random_byte()};
        return w;
    endfunction

    // one compare, counted, reported on mismatch
    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // all strobes down, receive bus quiet
    task automatic idle_bus();
        @(negedge LS2CPU);
        ctrl    = '0;
        scsi_rx = '0;
    endtask

    // one word in over SCSI, bo stepping 0 to 3
    // the push lands on the edge after the lane 3 drive
    task automatic receive_word(input logic [31:0] w);
        int lane;
        for (lane = 0; lane < 4; lane++) begin
            @(negedge LS2CPU);
            ctrl     = '0;
            ctrl.s2f = 1'b1;
            ctrl.bo  = 2'(lane);
            scsi_rx  = w[31 - 8 * lane -: 8];
        end
    endtask

    // one word out over SCSI, lane 0 first
    // transmit is combinational, checked in the low phase
    task automatic transmit_word(input logic [31:0] w);
        int lane;
        for (lane = 0; lane < 4; lane++) begin
            @(negedge LS2CPU);
            ctrl     = '0;
            ctrl.f2s = 1'b1;
            ctrl.bo  = 2'(lane);
            #5;
            check_equal("scsi_tx", w[31 - 8 * lane -: 8], scsi_tx);
            check_equal("scsi_oe", 1, scsi_oe);
        end
    endtask

    // quiet outputs and an empty FIFO straight out of reset
    task automatic verify_reset_state();
        idle_bus();
        #5;
        check_equal("scsi_oe", 0, scsi_oe);
        check_equal("mod", 0, mod);
        check_equal("stat.empty", 1, stat.empty);
        check_equal("stat.full", 0, stat.full);
        // latch reset value shows as soon as s2cpu rises, before any sample
        @(negedge LS2CPU);
        ctrl.s2cpu = 1'b1;
        #5;
        check_equal("mod", 0, mod);
        idle_bus();
    endtask

    // CPU write data onto the bus, both halves
    task automatic cpu_to_scsi();
        logic [31:0] w;
        repeat (4) begin
            w = random_word();
            @(negedge LS2CPU);
            ctrl       = '0;
            ctrl.cpu2s = 1'b1;
            ctrl.a3    = 1'b1;
            cpu_wdata  = w;
            #5;
            check_equal("scsi_tx", w[23:16], scsi_tx);
            check_equal("scsi_oe", 1, scsi_oe);
            @(negedge LS2CPU);
            ctrl.a3 = 1'b0;
            #5;
            check_equal("scsi_tx", w[7:0], scsi_tx);
            check_equal("scsi_oe", 1, scsi_oe);
        end
        // no strobe, bus released
        idle_bus();
        #5;
        check_equal("scsi_oe", 0, scsi_oe);
        check_equal("scsi_tx", 0, scsi_tx);
    endtask

    // received byte shows in the upper byte of each half after one edge
    task automatic scsi_to_cpu();
        logic [7:0] b;
        repeat (4) begin
            b = random_byte();
            @(negedge LS2CPU);
            ctrl       = '0;
            ctrl.s2cpu = 1'b1;
            scsi_rx    = b;
            @(posedge LS2CPU);
            #5;
            check_equal("mod", {b, 8'h00, b, 8'h00}, mod);
        end
        idle_bus();
        #5;
        check_equal("mod", 0, mod);
    endtask

    // four words packed in, then unpacked in the same order
    task automatic fifo_round_trip();
        logic [31:0] words [4];
        int i;
        for (i = 0; i < 4; i++) begin
            words[i] = random_word();
            receive_word(words[i]);
        end
        idle_bus();
        #5;
        check_equal("stat.empty", 0, stat.empty);
        for (i = 0; i < 4; i++) begin
            transmit_word(words[i]);
        end
        idle_bus();
        #5;
        check_equal("stat.empty", 1, stat.empty);
        check_equal("stat.full", 0, stat.full);
    endtask

    // overfill by one word, drain, then underrun
    task automatic fifo_full_empty();
        logic [31:0] words [DEPTH + 1];
        int i;
        for (i = 0; i <= DEPTH; i++) begin
            words[i] = random_word();
            receive_word(words[i]);
        end
        idle_bus();
        #5;
        check_equal("stat.full", 1, stat.full);
        check_equal("stat.empty", 0, stat.empty);
        // the extra word must not come back out
        for (i = 0; i < DEPTH; i++) begin
            transmit_word(words[i]);
        end
        idle_bus();
        #5;
        check_equal("stat.empty", 1, stat.empty);
        check_equal("stat.full", 0, stat.full);
        // f2s on an empty FIFO sends zero and pops nothing
        @(negedge LS2CPU);
        ctrl     = '0;
        ctrl.f2s = 1'b1;
        ctrl.bo  = word_pkg::LANE_LL;
        #5;
        check_equal("scsi_tx", 0, scsi_tx);
        check_equal("scsi_oe", 1, scsi_oe);
        @(posedge LS2CPU);
        #5;
        check_equal("stat.empty", 1, stat.empty);
        idle_bus();
    endtask

`endif

// ==== sim/tb_sdmac_datapath.sv ====
// testbench top with clock, reset, DUT instance, timeout and test sequence
`timescale 1ns/100ps

module tb_sdmac_datapath;

    // small FIFO so the full case is reached quickly
    localparam int DEPTH        = 4;
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;
    // well above the cycles the test sequence needs
    localparam int MAX_CYCLES   = 600;

    logic                 LS2CPU;
    logic                 rst_n;
    xfer_pkg::xfer_ctrl_t ctrl;
    word_pkg::data_word_u cpu_wdata;
    logic [7:0]           scsi_rx;
    logic [7:0]           scsi_tx;
    logic                 scsi_oe;
    word_pkg::data_word_u mod;
    xfer_pkg::fifo_stat_t stat;

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    `include "tb_tasks.svh"

    sdmac_datapath #(
        .FIFO_DEPTH (DEPTH)
    ) UUT (
        .LS2CPU    (LS2CPU),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .cpu_wdata (cpu_wdata),
        .scsi_rx   (scsi_rx),
        .scsi_tx   (scsi_tx),
        .scsi_oe   (scsi_oe),
        .mod       (mod),
        .stat      (stat)
    );

    // 40 ns clock
    initial begin
        LS2CPU = 1'b0;
        forever #HALF_PERIOD LS2CPU = ~LS2CPU;
    end

    // cycle limit, stops a hung run
    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge LS2CPU);
            cycle_count++;
        end
        error_count++;
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        $timeformat(-9, 1, " ns", 10);
        rst_n     = 1'b0;
        ctrl      = '0;
        cpu_wdata = '0;
        scsi_rx   = '0;
        repeat (RESET_CYCLES) @(posedge LS2CPU);
        @(negedge LS2CPU);
        rst_n = 1'b1;

        verify_reset_state();
        cpu_to_scsi();
        scsi_to_cpu();
        fifo_round_trip();
        fifo_full_empty();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+sim
hdl/word_pkg.sv
hdl/xfer_pkg.sv
hdl/scsi_tx_select.sv
hdl/scsi_datapath.sv
hdl/dma_fifo.sv
hdl/sdmac_datapath.sv
sim/tb_sdmac_datapath.sv

// ==== Bender.yml ====
package:
  name: sdmac_datapath

sources:
  # design, in compile order
  - files:
      - hdl/word_pkg.sv
      - hdl/xfer_pkg.sv
      - hdl/scsi_tx_select.sv
      - hdl/scsi_datapath.sv
      - hdl/dma_fifo.sv
      - hdl/sdmac_datapath.sv

  # testbench, top module tb_sdmac_datapath
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_sdmac_datapath.sv
